// ==== singleCpu.f ====
hdl/rvPkg.sv
hdl/instFetch.sv
hdl/regFile.sv
hdl/controlDecode.sv
hdl/immGen.sv
hdl/executeUnit.sv
hdl/dataMem.sv
hdl/singleCpu.sv
sim/singleCpu_chk.sv
sim/singleCpu_tb.sv

// ==== sim/program.hex ====
// One 32-bit RV32I instruction word per line, starting at address 0x00
// After each word: byte address, then the instruction in assembly
00500093 // 00 addi x1, x0, 5
ffd00113 // 04 addi x2, x0, -3
002081b3 // 08 add  x3, x1, x2
40208233 // 0c sub  x4, x1, x2
0020f2b3 // 10 and  x5, x1, x2
0020e333 // 14 or   x6, x1, x2
0020c3b3 // 18 xor  x7, x1, x2
00112433 // 1c slt  x8, x2, x1
00402423 // 20 sw   x4, 8(x0)
00802483 // 24 lw   x9, 8(x0)
00c02503 // 28 lw   x10, 12(x0)
00700013 // 2c addi x0, x0, 7
007005b3 // 30 add  x11, x0, x7
00108463 // 34 beq  x1, x1, 8
06300613 // 38 addi x12, x0, 99
00109463 // 3c bne  x1, x1, 8
0020a633 // 40 slt  x12, x1, x2
00000063 // 44 beq  x0, x0, 0

// ==== sim/singleCpu_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module singleCpu_tb;

    localparam int clkPeriod   = 8;
    localparam int resetCycles = 10;
    localparam int haltCycles  = 10;
    localparam int pcSteps     = 17;
    localparam int wbSteps     = 12;
    localparam logic [31:0] firstInstr = 32'h0050_0093; // addi x1, x0, 5

    typedef struct packed {
        logic [31:0] pc;
        logic [4:0]  rd;
        logic [31:0] value;
    } wbExpT;

    logic        CLK = 1'b0;
    logic        rst = 1'b1;
    logic [31:0] pc;
    logic [31:0] instr;
    logic        wbEn;
    logic [4:0]  wbAddr;
    logic [31:0] wbData;

    wbExpT       expWb [wbSteps];
    logic [31:0] expPc [pcSteps];
    int          wbIdx = 0;
    int          errorCount = 0;
    int          errorsAtStart = 0;
    int          testsPassed = 0;
    int          testsFailed = 0;

    singleCpu singleCpu_inst (.CLK(CLK), .rst(rst), .pc(pc), .instr(instr), .wbEn(wbEn),
                              .wbAddr(wbAddr), .wbData(wbData));

    always #(clkPeriod / 2) CLK = ~CLK;

    task automatic loadTables();
        // Hand-computed results of program.hex with x1 = 5 and x2 = -3
        expWb[0]  = {32'h00, 5'd1,  32'h0000_0005};
        expWb[1]  = {32'h04, 5'd2,  32'hffff_fffd};
        expWb[2]  = {32'h08, 5'd3,  32'h0000_0002};
        expWb[3]  = {32'h0c, 5'd4,  32'h0000_0008};
        expWb[4]  = {32'h10, 5'd5,  32'h0000_0005};
        expWb[5]  = {32'h14, 5'd6,  32'hffff_fffd};
        expWb[6]  = {32'h18, 5'd7,  32'hffff_fff8};
        expWb[7]  = {32'h1c, 5'd8,  32'h0000_0001}; // -3 < 5 signed
        expWb[8]  = {32'h24, 5'd9,  32'h0000_0008}; // Word stored at 0x08
        expWb[9]  = {32'h28, 5'd10, 32'h0000_0000}; // Unwritten word
        expWb[10] = {32'h30, 5'd11, 32'hffff_fff8};
        expWb[11] = {32'h40, 5'd12, 32'h0000_0000};
        // The taken beq skips 0x38 and the bne at 0x3c falls through
        expPc = '{32'h00, 32'h04, 32'h08, 32'h0c, 32'h10, 32'h14, 32'h18, 32'h1c,
                  32'h20, 32'h24, 32'h28, 32'h2c, 32'h30, 32'h34, 32'h3c, 32'h40,
                  32'h44};
    endtask

    task automatic compareValue(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        assert (got === exp) else begin
            errorCount++;
            $display("mismatch %s: got 0x%08h, expected 0x%08h", name, got, exp);
        end
    endtask

    task automatic expectTrue(input logic cond, input string what);
        assert (cond === 1'b1) else begin
            errorCount++;
            $display("error: %s", what);
        end
    endtask

    task automatic closeTest(input string name);
        if (errorCount == errorsAtStart) begin
            testsPassed++;
            $display("PASS  %s", name);
        end else begin
            testsFailed++;
            $display("FAIL  %s", name);
        end
        errorsAtStart = errorCount;
    endtask

    initial begin
        loadTables();
        repeat (resetCycles) begin
            @(negedge CLK);
            compareValue("pc", pc, 32'h0);
            compareValue("wbEn", wbEn, 32'h0);
        end
        closeTest("reset");
        rst = 1'b0;
        for (int i = 0; i < pcSteps; i++) begin
            if (i > 0) begin
                @(negedge CLK);
            end
            #1; // Let the combinational path settle
            compareValue("pc", pc, expPc[i]);
            if (i == 0) begin
                compareValue("instr", instr, firstInstr);
            end
            if (wbIdx < wbSteps && expWb[wbIdx].pc == expPc[i]) begin
                compareValue("wbEn", wbEn, 32'h1);
                compareValue("wbAddr", wbAddr, expWb[wbIdx].rd);
                compareValue("wbData", wbData, expWb[wbIdx].value);
                wbIdx++;
            end else begin
                compareValue("wbEn", wbEn, 32'h0); // Store, branch or x0 target
            end
            closeTest($sformatf("step %0d at pc 0x%02h", i, expPc[i]));
        end
        repeat (haltCycles) begin
            @(negedge CLK);
            #1;
            compareValue("pc", pc, expPc[pcSteps-1]);
            compareValue("wbEn", wbEn, 32'h0);
        end
        expectTrue(singleCpu_inst.chkInst.failures == 0, "bound assertions reported failures");
        closeTest("halt loop");
        $display("tests passed: %0d, tests failed: %0d, check errors: %0d",
                 testsPassed, testsFailed, errorCount);
        if (testsFailed == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // Reset plus program length with margin
    initial begin
        #((resetCycles + pcSteps + 20) * clkPeriod);
        $display("timeout: the program did not reach its halt loop in time");
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim/singleCpu_chk.sv ====
`timescale 1ns/1ps
`default_nettype none

module singleCpu_chk (
    input  logic        CLK,
    input  logic        rst,
    input  logic [31:0] pc,
    input  logic        wbEn,
    input  logic [4:0]  wbAddr
);
    import rvPkg::*;

    int failures = 0;

    noWbInReset: assert property (@(posedge CLK) rst |-> !wbEn)
        else begin
            failures++;
            $error("write-back strobe raised during reset");
        end

    // x0 writes must be dropped before the port
    noWbToX0: assert property (@(posedge CLK) wbEn |-> (wbAddr != 5'd0))
        else begin
            failures++;
            $error("write-back strobe raised for register x0");
        end

    pcAligned: assert property (@(posedge CLK) disable iff (rst) pc[1:0] == 2'b00)
        else begin
            failures++;
            $error("pc is not word aligned");
        end

    pcAfterReset: assert property (@(posedge CLK) $fell(rst) |-> (pc == resetPc))
        else begin
            failures++;
            $error("pc is not at the reset address in the first cycle after reset");
        end

endmodule

bind singleCpu singleCpu_chk chkInst (.CLK(CLK), .rst(rst), .pc(pc), .wbEn(wbEn),
                                      .wbAddr(wbAddr));

`default_nettype wire

// ==== hdl/singleCpu.sv ====
`timescale 1ns/1ps
`default_nettype none

module singleCpu (
    input  logic        CLK,
    input  logic        rst,
    output logic [31:0] pc,
    output logic [31:0] instr,  // Current instruction
    output logic        wbEn,
    output logic [4:0]  wbAddr,
    output logic [31:0] wbData
);
    import rvPkg::*;

    ctrlT        ctrl;
    wbT          wb;
    logic [31:0] imm;
    logic [31:0] rd1;
    logic [31:0] rd2;
    logic [31:0] aluResult;
    logic        branchTaken;
    logic [31:0] branchTarget;
    logic [31:0] readData;

    instFetch instFetch1 (.CLK(CLK), .rst(rst), .branchTaken(branchTaken),
                          .branchTarget(branchTarget), .pc(pc), .instr(instr));

    controlDecode controlDecode1 (.instr(instr), .rst(rst), .ctrl(ctrl));

    immGen immGen1 (.instr(instr), .imm(imm));

    regFile regFile1 (.CLK(CLK), .rst(rst), .rs1(instr[19:15]), .rs2(instr[24:20]),
                      .wb(wb), .rd1(rd1), .rd2(rd2));

    executeUnit executeUnit1 (.ctrl(ctrl), .pc(pc), .rd1(rd1), .rd2(rd2), .imm(imm),
                              .aluResult(aluResult), .branchTaken(branchTaken),
                              .branchTarget(branchTarget));

    dataMem dataMem1 (.CLK(CLK), .addr(aluResult), .writeData(rd2),
                      .memWrite(ctrl.memWrite), .readData(readData));

    // Writes to x0 are dropped here, never seen on the port
    assign wb.en   = ctrl.regWrite && (instr[11:7] != 5'd0) && !rst;
    assign wb.addr = instr[11:7];
    assign wb.data = ctrl.memToReg ? readData : aluResult;

    assign wbEn   = wb.en;
    assign wbAddr = wb.addr;
    assign wbData = wb.data;

endmodule

`default_nettype wire

// ==== hdl/dataMem.sv ====
`timescale 1ns/1ps
`default_nettype none

module dataMem (
    input  logic        CLK,
    input  logic [31:0] addr,
    input  logic [31:0] writeData,
    input  logic        memWrite,
    output logic [31:0] readData
);
    import rvPkg::*;

    logic [31:0] mem [dmemWords];
    logic [$clog2(dmemWords)-1:0] wordIdx;

    assign wordIdx = addr[$clog2(dmemWords)+1:2]; // Word aligned only

    initial begin
        for (int i = 0; i < dmemWords; i++) begin
            mem[i] = '0;
        end
    end

    always_ff @(posedge CLK) begin
        if (memWrite) begin
            mem[wordIdx] <= writeData;
        end
    end

    assign readData = mem[wordIdx];

endmodule

`default_nettype wire

// ==== hdl/executeUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

module executeUnit (
    input  rvPkg::ctrlT ctrl,
    input  logic [31:0] pc,
    input  logic [31:0] rd1,
    input  logic [31:0] rd2,
    input  logic [31:0] imm,
    output logic [31:0] aluResult,
    output logic        branchTaken,
    output logic [31:0] branchTarget
);
    import rvPkg::*;

    logic [31:0] opB;
    logic        zero;

    assign opB = ctrl.aluSrc ? imm : rd2;

    always_comb begin
        case (ctrl.aluOp)
            aluAdd: aluResult = rd1 + opB;
            aluSub: aluResult = rd1 - opB;
            aluAnd: aluResult = rd1 & opB;
            aluOr:  aluResult = rd1 | opB;
            aluXor: aluResult = rd1 ^ opB;
            aluSlt: begin
                // Signed compare
                aluResult = ($signed(rd1) < $signed(opB)) ? 32'd1 : 32'd0;
            end
            default: aluResult = 32'd0;
        endcase
    end

    assign zero = (aluResult == 32'd0);

    // beq takes on zero, bne on nonzero
    assign branchTaken  = ctrl.branch && (zero != ctrl.branchNe);
    assign branchTarget = pc + imm;

endmodule

`default_nettype wire

// ==== hdl/immGen.sv ====
`timescale 1ns/1ps
`default_nettype none

module immGen (
    input  logic [31:0] instr,
    output logic [31:0] imm
);
    import rvPkg::*;

    opcodeE opcode;

    assign opcode = opcodeE'(instr[6:0]);

    always_comb begin
        case (opcode)
            opImm, opLoad: begin
                imm = {{20{instr[31]}}, instr[31:20]};
            end
            opStore: begin
                imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            end
            opBranch: begin
                // Byte offset, always even
                imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
            end
            default: imm = 32'd0;
        endcase
    end

endmodule

`default_nettype wire

// ==== hdl/controlDecode.sv ====
`timescale 1ns/1ps
`default_nettype none

module controlDecode (
    input  logic [31:0] instr,
    input  logic        rst,
    output rvPkg::ctrlT ctrl
);
    import rvPkg::*;

    opcodeE     opcode;
    logic [2:0] funct3;
    logic       funct7b30;

    assign opcode    = opcodeE'(instr[6:0]);
    assign funct3    = instr[14:12];
    assign funct7b30 = instr[30];

    always_comb begin
        ctrl = '0;
        if (!rst) begin
            case (opcode)
                opReg: begin
                    ctrl.regWrite = 1'b1;
                    case (funct3)
                        3'b000:  ctrl.aluOp = funct7b30 ? aluSub : aluAdd;
                        3'b010:  ctrl.aluOp = aluSlt;
                        3'b100:  ctrl.aluOp = aluXor;
                        3'b110:  ctrl.aluOp = aluOr;
                        3'b111:  ctrl.aluOp = aluAnd;
                        default: ctrl.regWrite = 1'b0; // Shifts and sltu not supported
                    endcase
                end
                opImm: begin // Only addi
                    ctrl.regWrite = (funct3 == 3'b000);
                    ctrl.aluSrc   = 1'b1;
                end
                opLoad: begin
                    ctrl.regWrite = 1'b1;
                    ctrl.aluSrc   = 1'b1;
                    ctrl.memToReg = 1'b1;
                end
                opStore: begin
                    ctrl.aluSrc   = 1'b1;
                    ctrl.memWrite = 1'b1;
                end
                opBranch: begin
                    ctrl.branch   = 1'b1;
                    ctrl.branchNe = (funct3 == 3'b001);
                    ctrl.aluOp    = aluSub; // Compare by subtraction
                end
                default: ctrl = '0;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hdl/regFile.sv ====
`timescale 1ns/1ps
`default_nettype none

module regFile (
    input  logic        CLK,
    input  logic        rst,
    input  logic [4:0]  rs1,
    input  logic [4:0]  rs2,
    input  rvPkg::wbT   wb,
    output logic [31:0] rd1,
    output logic [31:0] rd2
);

    logic [31:0] regs [32];

    always_ff @(posedge CLK) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.en) begin
            regs[wb.addr] <= wb.data;
        end
    end

    // x0 reads as zero regardless of array contents
    assign rd1 = (rs1 == 5'd0) ? 32'd0 : regs[rs1];
    assign rd2 = (rs2 == 5'd0) ? 32'd0 : regs[rs2];

endmodule

`default_nettype wire

// ==== hdl/instFetch.sv ====
`timescale 1ns/1ps
`default_nettype none

module instFetch (
    input  logic        CLK,
    input  logic        rst,
    input  logic        branchTaken,
    input  logic [31:0] branchTarget,
    output logic [31:0] pc,
    output logic [31:0] instr
);
    import rvPkg::*;

    logic [31:0] rom [imemWords];
    logic [31:0] nextPc;

    initial begin
        $readmemh("sim/program.hex", rom);
    end

    // Taken branch wins over sequential fetch
    assign nextPc = branchTaken ? branchTarget : pc + 32'd4;

    always_ff @(posedge CLK) begin
        if (rst) begin
            pc <= resetPc;
        end else begin
            pc <= nextPc;
        end
    end

    // Word index without the two low bits
    assign instr = rom[pc[$clog2(imemWords)+1:2]];

endmodule

`default_nettype wire

// ==== hdl/rvPkg.sv ====
`default_nettype none

package rvPkg;

    // Major opcodes of the supported RV32I subset
    typedef enum logic [6:0] {
        opReg    = 7'b0110011,
        opImm    = 7'b0010011,
        opLoad   = 7'b0000011,
        opStore  = 7'b0100011,
        opBranch = 7'b1100011
    } opcodeE;

    typedef enum logic [2:0] {
        aluAdd = 3'd0, // Zero value, so a cleared ctrl means add
        aluSub = 3'd1,
        aluAnd = 3'd2,
        aluOr  = 3'd3,
        aluXor = 3'd4,
        aluSlt = 3'd5
    } aluOpE;

    // Main control bundle from the decoder
    typedef struct packed {
        logic  regWrite;
        logic  aluSrc;   // Immediate as second ALU operand
        logic  memWrite;
        logic  memToReg;
        logic  branch;
        logic  branchNe; // bne instead of beq
        aluOpE aluOp;
    } ctrlT;

    // Register write-back port
    typedef struct packed {
        logic        en;
        logic [4:0]  addr;
        logic [31:0] data;
    } wbT;

    localparam int imemWords = 64;
    localparam int dmemWords = 64;
    localparam logic [31:0] resetPc = 32'h0000_0000;

endpackage

`default_nettype wire
